// File: hw/prf_pkg.sv
// physical register file package
// sizes, index and data types shared by the register file blocks

package prf_pkg;

    // ------------------------------------------------------------------------
    // sizes

    // read requesters, one per operand read port
    localparam int PRF_RR_COUNT = 4;

    // writeback requesters, one per result bus
    localparam int PRF_WR_COUNT = 3;

    // physical registers in the array
    localparam int PR_COUNT = 64;

    // bits in a physical register index
    localparam int LOG_PR_COUNT = 6;

    // data word width
    localparam int WORD_WIDTH = 32;

    // ------------------------------------------------------------------------
    // types

    // physical register index, 0 is the hard zero register
    typedef logic [LOG_PR_COUNT-1:0] pr_t;

    // one register data word
    typedef logic [WORD_WIDTH-1:0] word_t;

endpackage

// File: hw/prf_write_merge.sv
// writeback merge for the physical register file
// keeps one winning writer per register index and drops writes to register 0

`timescale 1ns/1ns

module prf_write_merge (

    // raw writeback valids by writer
    input  logic [prf_pkg::PRF_WR_COUNT-1:0]               WB_valid_by_wr,

    // writeback target index by writer
    input  prf_pkg::pr_t [prf_pkg::PRF_WR_COUNT-1:0]       WB_PR_by_wr,

    // writers that actually update the array this cycle
    output logic [prf_pkg::PRF_WR_COUNT-1:0]               win_valid_by_wr
);

    // ------------------------------------------------------------------------
    // per-writer qualifiers

    // writer targets a real register, not the zero register
    logic [prf_pkg::PRF_WR_COUNT-1:0] nonzero_by_wr;

    // a higher-numbered valid writer hits the same index
    logic [prf_pkg::PRF_WR_COUNT-1:0] overridden_by_wr;

    // zero register check
    always_comb begin
        for (int wr = 0; wr < prf_pkg::PRF_WR_COUNT; wr++) begin
            nonzero_by_wr[wr] = (WB_PR_by_wr[wr] != '0);
        end
    end

    // pairwise compare against every higher-numbered writer
    // the highest-numbered writer always wins a conflict
    always_comb begin
        overridden_by_wr = '0;
        for (int wr = 0; wr < prf_pkg::PRF_WR_COUNT; wr++) begin
            for (int hi = wr + 1; hi < prf_pkg::PRF_WR_COUNT; hi++) begin
                // only a valid younger write can knock this one out
                if (WB_valid_by_wr[hi] && (WB_PR_by_wr[hi] == WB_PR_by_wr[wr])) begin
                    overridden_by_wr[wr] = 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // winners

    // a writer wins when valid, not to register 0 and not overridden
    // at most one winner per index, so array writes never collide
    always_comb begin
        for (int wr = 0; wr < prf_pkg::PRF_WR_COUNT; wr++) begin
            win_valid_by_wr[wr] = WB_valid_by_wr[wr]
                && nonzero_by_wr[wr]
                && ~overridden_by_wr[wr];
        end
    end

endmodule

// File: hw/prf_read_bypass.sv
// read bypass for the physical register file
// forwards same-cycle winning writeback data ahead of the array read

`timescale 1ns/1ns

module prf_read_bypass (

    // read index by requester
    input  prf_pkg::pr_t  [prf_pkg::PRF_RR_COUNT-1:0]      read_req_PR_by_rr,

    // plain array read by requester
    input  prf_pkg::word_t [prf_pkg::PRF_RR_COUNT-1:0]     array_data_by_rr,

    // winning writers from the merge
    input  logic [prf_pkg::PRF_WR_COUNT-1:0]               win_valid_by_wr,

    // writeback index and data by writer
    input  prf_pkg::pr_t  [prf_pkg::PRF_WR_COUNT-1:0]      WB_PR_by_wr,
    input  prf_pkg::word_t [prf_pkg::PRF_WR_COUNT-1:0]     WB_data_by_wr,

    // final read data by requester
    output prf_pkg::word_t [prf_pkg::PRF_RR_COUNT-1:0]     read_resp_data_by_rr
);

    // ------------------------------------------------------------------------
    // match matrix

    // hit_by_rr[rr][wr] set when writer wr wins and targets requester rr's index
    logic [prf_pkg::PRF_RR_COUNT-1:0][prf_pkg::PRF_WR_COUNT-1:0] hit_by_rr;

    // index 0 never wins, so no hit ever lands on the zero register
    always_comb begin
        for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
            for (int wr = 0; wr < prf_pkg::PRF_WR_COUNT; wr++) begin
                hit_by_rr[rr][wr] = win_valid_by_wr[wr]
                    && (WB_PR_by_wr[wr] == read_req_PR_by_rr[rr]);
            end
        end
    end

    // ------------------------------------------------------------------------
    // data select

    // default to the array, override with the matching winner
    // winners have distinct indices, so at most one hit per requester
    always_comb begin
        for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
            read_resp_data_by_rr[rr] = array_data_by_rr[rr];
            for (int wr = 0; wr < prf_pkg::PRF_WR_COUNT; wr++) begin
                if (hit_by_rr[rr][wr]) begin
                    read_resp_data_by_rr[rr] = WB_data_by_wr[wr];
                end
            end
        end
    end

    // register 0 reads come straight from the array, which holds zero there

endmodule

// File: hw/prf_ff.sv
// flip-flop physical register file core
// storage array with merged writeback ports and bypassed read ports

`timescale 1ns/1ns

module prf_ff (

    // seq
    input  logic                                           CLK,
    input  logic                                           nRST,

    // read index by requester
    input  prf_pkg::pr_t  [prf_pkg::PRF_RR_COUNT-1:0]      read_req_PR_by_rr,

    // writeback info by writer
    input  logic [prf_pkg::PRF_WR_COUNT-1:0]               WB_valid_by_wr,
    input  prf_pkg::word_t [prf_pkg::PRF_WR_COUNT-1:0]     WB_data_by_wr,
    input  prf_pkg::pr_t  [prf_pkg::PRF_WR_COUNT-1:0]      WB_PR_by_wr,

    // read data by requester, combinational from this cycle's inputs
    output prf_pkg::word_t [prf_pkg::PRF_RR_COUNT-1:0]     read_resp_data_by_rr
);

    // ------------------------------------------------------------------------
    // internal signals

    // storage, one word per physical register
    prf_pkg::word_t [prf_pkg::PR_COUNT-1:0]    reg_array;

    // writers that update the array this cycle
    logic [prf_pkg::PRF_WR_COUNT-1:0]          win_valid_by_wr;

    // raw array read by requester, before bypass
    prf_pkg::word_t [prf_pkg::PRF_RR_COUNT-1:0] array_data_by_rr;

    // ------------------------------------------------------------------------
    // write side

    prf_write_merge write_merge (
        .WB_valid_by_wr (WB_valid_by_wr),
        .WB_PR_by_wr    (WB_PR_by_wr),
        .win_valid_by_wr(win_valid_by_wr)
    );

    // array update, winners never share an index so loop order is irrelevant
    // entry 0 is never a winner target and stays at its reset value
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            reg_array <= '0;
        end else begin
            for (int wr = 0; wr < prf_pkg::PRF_WR_COUNT; wr++) begin
                if (win_valid_by_wr[wr]) begin
                    reg_array[WB_PR_by_wr[wr]] <= WB_data_by_wr[wr];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // read side

    // one 64:1 mux per requester
    always_comb begin
        for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
            array_data_by_rr[rr] = reg_array[read_req_PR_by_rr[rr]];
        end
    end

    // same-cycle writes take priority over the stored value
    prf_read_bypass read_bypass (
        .read_req_PR_by_rr   (read_req_PR_by_rr),
        .array_data_by_rr    (array_data_by_rr),
        .win_valid_by_wr     (win_valid_by_wr),
        .WB_PR_by_wr         (WB_PR_by_wr),
        .WB_data_by_wr       (WB_data_by_wr),
        .read_resp_data_by_rr(read_resp_data_by_rr)
    );

endmodule

// File: hw/prf_ff_wrapper.sv
// top level of the flip-flop physical register file
// flops every input and output around prf_ff, giving two edges of read latency

`timescale 1ns/1ns

module prf_ff_wrapper (

    // seq
    input  logic                                           CLK,
    input  logic                                           nRST,

    // read index by requester, sampled next edge
    input  prf_pkg::pr_t  [prf_pkg::PRF_RR_COUNT-1:0]      next_read_req_PR_by_rr,

    // read data by requester, registered
    output prf_pkg::word_t [prf_pkg::PRF_RR_COUNT-1:0]     last_read_resp_data_by_rr,

    // writeback info by writer, sampled next edge
    input  logic [prf_pkg::PRF_WR_COUNT-1:0]               next_WB_valid_by_wr,
    input  prf_pkg::word_t [prf_pkg::PRF_WR_COUNT-1:0]     next_WB_data_by_wr,
    input  prf_pkg::pr_t  [prf_pkg::PRF_WR_COUNT-1:0]      next_WB_PR_by_wr
);

    // ------------------------------------------------------------------------
    // boundary copies feeding the core

    // read requests
    prf_pkg::pr_t  [prf_pkg::PRF_RR_COUNT-1:0]  read_req_PR_by_rr;

    // read responses before the output flops
    prf_pkg::word_t [prf_pkg::PRF_RR_COUNT-1:0] read_resp_data_by_rr;

    // writebacks
    logic [prf_pkg::PRF_WR_COUNT-1:0]           WB_valid_by_wr;
    prf_pkg::word_t [prf_pkg::PRF_WR_COUNT-1:0] WB_data_by_wr;
    prf_pkg::pr_t  [prf_pkg::PRF_WR_COUNT-1:0]  WB_PR_by_wr;

    // ------------------------------------------------------------------------
    // core

    prf_ff prf (
        .CLK                 (CLK),
        .nRST                (nRST),
        .read_req_PR_by_rr   (read_req_PR_by_rr),
        .WB_valid_by_wr      (WB_valid_by_wr),
        .WB_data_by_wr       (WB_data_by_wr),
        .WB_PR_by_wr         (WB_PR_by_wr),
        .read_resp_data_by_rr(read_resp_data_by_rr)
    );

    // ------------------------------------------------------------------------
    // input flops

    // clearing the valids keeps the array untouched out of reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            read_req_PR_by_rr <= '0;
            WB_valid_by_wr    <= '0;
            WB_data_by_wr     <= '0;
            WB_PR_by_wr       <= '0;
        end else begin
            read_req_PR_by_rr <= next_read_req_PR_by_rr;
            WB_valid_by_wr    <= next_WB_valid_by_wr;
            WB_data_by_wr     <= next_WB_data_by_wr;
            WB_PR_by_wr       <= next_WB_PR_by_wr;
        end
    end

    // ------------------------------------------------------------------------
    // output flops

    // second edge of the read path
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            last_read_resp_data_by_rr <= '0;
        end else begin
            last_read_resp_data_by_rr <= read_resp_data_by_rr;
        end
    end

endmodule

// File: sim/prf_ff_tb.sv
// testbench for the flip-flop physical register file
// plays one stimulus line per cycle and checks the registered read data

`timescale 1ns/1ns

module prf_ff_tb;

    // ------------------------------------------------------------------------
    // testbench constants

    localparam int CLK_PERIOD = 4;
    localparam int FIELD_COUNT = 17;
    localparam string STIM_FILE = "sim/prf_input.txt";

    // ------------------------------------------------------------------------
    // DUT signals

    logic CLK;
    logic nRST;

    prf_pkg::pr_t   [prf_pkg::PRF_RR_COUNT-1:0] next_read_req_PR_by_rr;
    prf_pkg::word_t [prf_pkg::PRF_RR_COUNT-1:0] last_read_resp_data_by_rr;
    logic           [prf_pkg::PRF_WR_COUNT-1:0] next_WB_valid_by_wr;
    prf_pkg::word_t [prf_pkg::PRF_WR_COUNT-1:0] next_WB_data_by_wr;
    prf_pkg::pr_t   [prf_pkg::PRF_WR_COUNT-1:0] next_WB_PR_by_wr;

    // ------------------------------------------------------------------------
    // stimulus store, one entry per data line

    logic           [prf_pkg::PRF_WR_COUNT-1:0] valid_q[$];
    prf_pkg::pr_t   [prf_pkg::PRF_WR_COUNT-1:0] wpr_q[$];
    prf_pkg::word_t [prf_pkg::PRF_WR_COUNT-1:0] wdata_q[$];
    prf_pkg::pr_t   [prf_pkg::PRF_RR_COUNT-1:0] rpr_q[$];
    prf_pkg::word_t [prf_pkg::PRF_RR_COUNT-1:0] exp_q[$];
    // source line of each entry, for error lines
    int src_line_q[$];

    // error and check counters
    int check_errors = 0;
    int file_errors = 0;
    int checks_run = 0;

    // set once the data file is read, starts the watchdog
    bit loaded = 1'b0;

    // ------------------------------------------------------------------------
    // clock and DUT

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    prf_ff_wrapper uut (
        .CLK                      (CLK),
        .nRST                     (nRST),
        .next_read_req_PR_by_rr   (next_read_req_PR_by_rr),
        .last_read_resp_data_by_rr(last_read_resp_data_by_rr),
        .next_WB_valid_by_wr      (next_WB_valid_by_wr),
        .next_WB_data_by_wr       (next_WB_data_by_wr),
        .next_WB_PR_by_wr         (next_WB_PR_by_wr)
    );

    // ------------------------------------------------------------------------
    // data file reading

    // comment and blank lines carry no stimulus
    function automatic bit is_skip_line(input string text);
        byte first;
        if (text.len() == 0) begin
            return 1'b1;
        end
        first = text.getc(0);
        return (first == "#") || (first == "\n") || (first == "\r");
    endfunction

    // split one data line into the stimulus queues
    task automatic parse_line(input string text, input int line_no);
        int rc;
        bit bad;
        logic [31:0] field [FIELD_COUNT];
        logic           [prf_pkg::PRF_WR_COUNT-1:0] valid_v;
        prf_pkg::pr_t   [prf_pkg::PRF_WR_COUNT-1:0] wpr_v;
        prf_pkg::word_t [prf_pkg::PRF_WR_COUNT-1:0] wdata_v;
        prf_pkg::pr_t   [prf_pkg::PRF_RR_COUNT-1:0] rpr_v;
        prf_pkg::word_t [prf_pkg::PRF_RR_COUNT-1:0] exp_v;
        if (is_skip_line(text)) begin
            return;
        end
        rc = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            field[0], field[1], field[2], field[3], field[4], field[5],
            field[6], field[7], field[8], field[9], field[10], field[11],
            field[12], field[13], field[14], field[15], field[16]);
        if (rc != FIELD_COUNT) begin
            $display("malformed line %0d in %s: found %0d of %0d fields",
                line_no, STIM_FILE, rc, FIELD_COUNT);
            file_errors++;
            return;
        end
        // valid must be a single bit and every index must fit the array
        bad = 1'b0;
        for (int wr = 0; wr < prf_pkg::PRF_WR_COUNT; wr++) begin
            if (field[wr*3] > 1 || field[wr*3+1] >= prf_pkg::PR_COUNT) begin
                bad = 1'b1;
            end
        end
        for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
            if (field[9+rr] >= prf_pkg::PR_COUNT) begin
                bad = 1'b1;
            end
        end
        if (bad) begin
            $display("malformed line %0d in %s: a valid or index is out of range",
                line_no, STIM_FILE);
            file_errors++;
            return;
        end
        for (int wr = 0; wr < prf_pkg::PRF_WR_COUNT; wr++) begin
            valid_v[wr] = field[wr*3][0];
            wpr_v[wr]   = field[wr*3+1][prf_pkg::LOG_PR_COUNT-1:0];
            wdata_v[wr] = field[wr*3+2];
        end
        for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
            rpr_v[rr] = field[9+rr][prf_pkg::LOG_PR_COUNT-1:0];
            exp_v[rr] = field[13+rr];
        end
        valid_q.push_back(valid_v);
        wpr_q.push_back(wpr_v);
        wdata_q.push_back(wdata_v);
        rpr_q.push_back(rpr_v);
        exp_q.push_back(exp_v);
        src_line_q.push_back(line_no);
    endtask

    task automatic load_stimulus();
        int fd;
        int rc;
        int line_no;
        string text;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            file_errors++;
            return;
        end
        line_no = 0;
        rc = $fgets(text, fd);
        while (rc != 0) begin
            line_no++;
            parse_line(text, line_no);
            rc = $fgets(text, fd);
        end
        $fclose(fd);
        if (exp_q.size() == 0) begin
            $display("the stimulus file %s holds no data lines", STIM_FILE);
            file_errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // drive and check

    task automatic drive_line(input int idx);
        next_WB_valid_by_wr    <= valid_q[idx];
        next_WB_PR_by_wr       <= wpr_q[idx];
        next_WB_data_by_wr     <= wdata_q[idx];
        next_read_req_PR_by_rr <= rpr_q[idx];
    endtask

    // flushes the pipe after the last line
    task automatic drive_idle();
        next_WB_valid_by_wr    <= '0;
        next_WB_PR_by_wr       <= '0;
        next_WB_data_by_wr     <= '0;
        next_read_req_PR_by_rr <= '0;
    endtask

    task automatic compare_word(input prf_pkg::word_t actual, input prf_pkg::word_t expected,
                                input int rr, input int line_no);
        checks_run++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: data line %0d requester %0d got %h expected %h",
                $time, line_no, rr, actual, expected);
            check_errors++;
        end
    endtask

    task automatic check_line(input int idx);
        for (int rr = 0; rr < prf_pkg::PRF_RR_COUNT; rr++) begin
            compare_word(last_read_resp_data_by_rr[rr], exp_q[idx][rr], rr, src_line_q[idx]);
        end
    endtask

    // line n goes in on edge k and its data sits on the outputs after edge k+2
    // sampled at the falling edge, away from the flop updates
    task automatic play_lines();
        int n_lines;
        n_lines = exp_q.size();
        for (int cyc = 0; cyc < n_lines + 2; cyc++) begin
            @(posedge CLK);
            if (cyc < n_lines) begin
                drive_line(cyc);
            end else begin
                drive_idle();
            end
            @(negedge CLK);
            if (cyc >= 2) begin
                check_line(cyc - 2);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence

    initial begin : main
        nRST = 1'b0;
        next_WB_valid_by_wr    = '0;
        next_WB_PR_by_wr       = '0;
        next_WB_data_by_wr     = '0;
        next_read_req_PR_by_rr = '0;
        load_stimulus();
        loaded = 1'b1;
        // two cycles of reset
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        if (file_errors == 0) begin
            play_lines();
        end
        $display("check errors %0d, file errors %0d, checks run %0d",
            check_errors, file_errors, checks_run);
        if (check_errors == 0 && file_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // ------------------------------------------------------------------------
    // watchdog

    // limit grows with the number of data lines
    initial begin : watchdog
        int limit_ns;
        wait (loaded);
        limit_ns = (exp_q.size() + 10) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: sim/prf_input.txt
# wr0 v pr data | wr1 v pr data | wr2 v pr data | read pr 0..3 | expected read data 0..3
# all fields hex, one line per cycle, expected data appears two edges after its line
# reset state reads zero
0 00 00000000  0 00 00000000  0 00 00000000  00 01 3f 20  00000000 00000000 00000000 00000000
0 00 00000000  0 00 00000000  0 00 00000000  05 0a 10 2a  00000000 00000000 00000000 00000000
# writes, later reads and overwrite
1 05 11110005  0 00 00000000  0 00 00000000  01 02 03 04  00000000 00000000 00000000 00000000
0 00 00000000  1 0a 2222000a  0 00 00000000  05 01 02 00  11110005 00000000 00000000 00000000
0 00 00000000  0 00 00000000  1 10 33330010  05 0a 05 0a  11110005 2222000a 11110005 2222000a
0 00 00000000  0 00 00000000  0 00 00000000  10 05 0a 11  33330010 11110005 2222000a 00000000
1 05 aaaa0005  0 00 00000000  0 00 00000000  0a 10 01 06  2222000a 33330010 00000000 00000000
0 00 00000000  0 00 00000000  0 00 00000000  05 05 0a 10  aaaa0005 aaaa0005 2222000a 33330010
1 3f deadbeef  1 01 00000101  1 20 cafe0020  05 00 02 03  aaaa0005 00000000 00000000 00000000
0 00 00000000  0 00 00000000  0 00 00000000  3f 01 20 05  deadbeef 00000101 cafe0020 aaaa0005
# same-cycle read of a register being written
1 07 07070707  0 00 00000000  0 00 00000000  07 06 07 00  07070707 00000000 07070707 00000000
0 00 00000000  1 07 17171717  0 00 00000000  07 07 07 07  17171717 17171717 17171717 17171717
1 09 09090909  0 00 00000000  1 08 08080808  08 09 07 0a  08080808 09090909 17171717 2222000a
0 00 00000000  0 00 00000000  0 00 00000000  08 09 07 3f  08080808 09090909 17171717 deadbeef
1 3f 3f3f3f3f  1 01 01010101  0 00 00000000  3f 01 3f 01  3f3f3f3f 01010101 3f3f3f3f 01010101
1 11 aaaa0011  0 00 00000000  0 00 00000000  11 10 0f 01  aaaa0011 33330010 00000000 01010101
1 11 bbbb0011  0 00 00000000  0 00 00000000  11 11 10 12  bbbb0011 bbbb0011 33330010 00000000
0 00 00000000  0 00 00000000  1 11 cccc0011  11 12 13 14  cccc0011 00000000 00000000 00000000
0 00 00000000  0 00 00000000  0 00 00000000  11 05 07 08  cccc0011 aaaa0005 17171717 08080808
# same-cycle writer conflicts, highest writer wins
1 12 00000012  1 12 11110012  0 00 00000000  12 12 00 13  11110012 11110012 00000000 00000000
0 00 00000000  0 00 00000000  0 00 00000000  12 11 10 0a  11110012 cccc0011 33330010 2222000a
1 13 00000013  0 00 00000000  1 13 22220013  13 12 13 00  22220013 11110012 22220013 00000000
0 00 00000000  1 14 11110014  1 14 22220014  14 13 12 11  22220014 22220013 11110012 cccc0011
1 15 00000015  1 15 11110015  1 15 22220015  15 15 15 15  22220015 22220015 22220015 22220015
0 00 00000000  0 00 00000000  0 00 00000000  15 14 13 12  22220015 22220014 22220013 11110012
1 16 00000016  1 16 11110016  1 17 22220017  16 17 15 00  11110016 22220017 22220015 00000000
1 18 00000018  1 19 11110019  1 18 22220018  18 19 16 17  22220018 11110019 11110016 22220017
1 1a 0000001a  0 1a ffffffff  0 1a eeeeeeee  1a 1a 18 19  0000001a 0000001a 22220018 11110019
0 00 00000000  0 00 00000000  0 00 00000000  1a 18 19 16  0000001a 22220018 11110019 11110016
# register 0 ignores writes and reads zero
1 00 12345678  0 00 00000000  0 00 00000000  00 00 00 00  00000000 00000000 00000000 00000000
0 00 00000000  1 00 87654321  1 00 ffffffff  00 00 00 00  00000000 00000000 00000000 00000000
1 1b 0000001b  1 00 11111111  1 00 22222222  00 1b 00 1b  00000000 0000001b 00000000 0000001b
0 00 00000000  0 00 00000000  0 00 00000000  00 00 00 00  00000000 00000000 00000000 00000000
1 1c 0000001c  0 00 00000000  1 00 deadbeef  1c 00 1c 00  0000001c 00000000 0000001c 00000000
# back-to-back traffic on all requesters
1 21 a0000021  1 22 b0000022  1 23 c0000023  21 22 23 20  a0000021 b0000022 c0000023 cafe0020
1 24 a0000024  1 21 b0000021  1 25 c0000025  21 24 25 22  b0000021 a0000024 c0000025 b0000022
1 22 a0000022  0 00 00000000  1 26 c0000026  22 22 26 23  a0000022 a0000022 c0000026 c0000023
1 23 a0000023  1 23 b0000023  1 27 c0000027  23 27 21 3f  b0000023 c0000027 b0000021 3f3f3f3f
0 00 00000000  1 28 b0000028  1 21 c0000021  21 21 28 24  c0000021 c0000021 b0000028 a0000024
1 29 a0000029  1 2a b000002a  1 2b c000002b  29 2a 2b 25  a0000029 b000002a c000002b c0000025
1 2c a000002c  1 2d b000002d  1 2c c000002c  2c 2d 26 27  c000002c b000002d c0000026 c0000027
0 00 00000000  0 00 00000000  0 00 00000000  21 22 23 24  c0000021 a0000022 b0000023 a0000024
0 00 00000000  0 00 00000000  0 00 00000000  25 26 27 28  c0000025 c0000026 c0000027 b0000028
1 29 a1000029  0 00 00000000  0 00 00000000  29 2a 2b 2c  a1000029 b000002a c000002b c000002c
1 2a a100002a  1 29 b1000029  1 2d c100002d  29 2a 2d 00  b1000029 a100002a c100002d 00000000
0 00 00000000  0 00 00000000  0 00 00000000  29 2a 2d 2d  b1000029 a100002a c100002d c100002d
1 30 a0000030  1 31 b0000031  1 32 c0000032  30 31 32 33  a0000030 b0000031 c0000032 00000000
1 33 a0000033  1 30 b0000030  1 31 c0000031  30 31 32 33  b0000030 c0000031 c0000032 a0000033
1 32 a0000032  1 32 b0000032  1 33 c0000033  30 31 32 33  b0000030 c0000031 b0000032 c0000033
0 00 00000000  0 00 00000000  0 00 00000000  33 32 31 30  c0000033 b0000032 c0000031 b0000030
# final sweep of stored values
0 00 00000000  0 00 00000000  0 00 00000000  05 0a 10 3f  aaaa0005 2222000a 33330010 3f3f3f3f
0 00 00000000  0 00 00000000  0 00 00000000  01 07 11 20  01010101 17171717 cccc0011 cafe0020
0 00 00000000  0 00 00000000  0 00 00000000  12 13 14 15  11110012 22220013 22220014 22220015
0 00 00000000  0 00 00000000  0 00 00000000  16 17 18 19  11110016 22220017 22220018 11110019
0 00 00000000  0 00 00000000  0 00 00000000  1a 1b 1c 00  0000001a 0000001b 0000001c 00000000
0 00 00000000  0 00 00000000  0 00 00000000  21 29 2d 00  c0000021 b1000029 c100002d 00000000
0 00 00000000  0 00 00000000  0 00 00000000  3f 3f 3f 3f  3f3f3f3f 3f3f3f3f 3f3f3f3f 3f3f3f3f

// File: all.f
hw/prf_pkg.sv
hw/prf_write_merge.sv
hw/prf_read_bypass.sv
hw/prf_ff.sv
hw/prf_ff_wrapper.sv
sim/prf_ff_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the register file testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns -f all.f --top-module prf_ff_tb \
        -o prf_ff_tb_sim \
    && ./obj_dir/prf_ff_tb_sim | tee sim.log \
    && grep -qx "Finished with no errors" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
